//--- run.sh
#!/usr/bin/env bash
# Build and run the Thor decode stage simulation with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -f thorDecode.f --top-module thorDecodeTb -Mdir obj_dir; then
	echo "Verilator build failed"
	exit 1
fi

simOut=$(./obj_dir/VthorDecodeTb)
simStatus=$?
printf '%s\n' "$simOut"

if [ "$simStatus" -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -qx "All checks passed" <<< "$simOut"; then
	exit 0
else
	echo "Pass message not found in simulation output"
	exit 1
fi

//--- src/flowDecode.sv
`timescale 1ns/100ps
// ============================
// Flow-change decode
// Jump and branch kinds and the branch target
// ============================
module flowDecode #(
	parameter int ValueWidth = 64
) (
	input  logic clk,
	input  logic rstN,
	input  thorDecodePkg::insnFmt insn,
	input  logic insnValid,
	output logic isJump,
	output logic isCondBranch,
	output logic isBranch,
	output logic isReturn,
	output logic isFlowChange,
	output logic [ValueWidth-1:0] branchTarget
);

	localparam int LongWidth = thorDecodePkg::InsnWidth - 9;

	thorDecodePkg::opcodeT op;
	logic jumpNext;
	logic condNext;
	logic braNext;
	logic retNext;
	logic [ValueWidth-1:0] targetNext;

	assign op = insn.r3.opcode;
	assign jumpNext = op == thorDecodePkg::JMP;
	assign condNext = op inside {thorDecodePkg::JEQ, thorDecodePkg::JNE, thorDecodePkg::JLT};
	assign braNext = op == thorDecodePkg::BRA;
	assign retNext = op == thorDecodePkg::RTS;

	// Targets count halfwords, so bit 0 is always clear
	always_comb
	begin
		if (condNext)
			targetNext = {{(ValueWidth-19){insn.jxx.tgt[17]}}, insn.jxx.tgt, 1'b0};
		else if (jumpNext || braNext)
			targetNext = {{(ValueWidth-LongWidth-1){insn.jmp.tgt[LongWidth-1]}},
				insn.jmp.tgt, 1'b0};
		else
			targetNext = '0;
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			isJump <= 1'b0;
			isCondBranch <= 1'b0;
			isBranch <= 1'b0;
			isReturn <= 1'b0;
			isFlowChange <= 1'b0;
			branchTarget <= '0;
		end
		else
		begin
			isJump <= jumpNext;
			isCondBranch <= condNext;
			isBranch <= braNext;
			isReturn <= retNext;
			isFlowChange <= jumpNext | condNext | braNext | retNext;
			branchTarget <= targetNext;
		end
	end

endmodule

//--- src/immBuild.sv
`timescale 1ns/100ps
// ============================
// Immediate builder
// Base constant, merged with a pending EXI prefix
// ============================
module immBuild #(
	parameter int ValueWidth = 64
) (
	input  logic clk,
	input  logic rstN,
	input  thorDecodePkg::insnFmt insn,
	input  logic insnValid,
	output logic [ValueWidth-1:0] imm,
	output logic isPrefix
);

	localparam int PayloadWidth = thorDecodePkg::InsnWidth - 7;

	thorDecodePkg::opcodeT op;
	logic [ValueWidth-1:0] baseImm;
	logic [ValueWidth-1:0] immNext;
	logic isExi;
	logic pendValid;
	logic [PayloadWidth-1:0] pendPayload;

	assign op = insn.r3.opcode;
	assign isExi = op == thorDecodePkg::EXI;

	// ============================
	// Base constant
	// ============================
	always_comb
	begin
		case (op)
			thorDecodePkg::ADDI:
				baseImm = {{(ValueWidth-23){insn.ri.imm[22]}}, insn.ri.imm};
			thorDecodePkg::LDB, thorDecodePkg::LDBU, thorDecodePkg::LDW,
			thorDecodePkg::LDWU, thorDecodePkg::LDO,
			thorDecodePkg::STB, thorDecodePkg::STW, thorDecodePkg::STO:
				baseImm = {{(ValueWidth-23){insn.mem.disp[22]}}, insn.mem.disp};
			// Ones on the left keep the upper bits of the operand
			thorDecodePkg::ANDI:
				baseImm = {{(ValueWidth-23){1'b1}}, insn.ri.imm};
			thorDecodePkg::ORI, thorDecodePkg::SLTUI:
				baseImm = {{(ValueWidth-23){1'b0}}, insn.ri.imm};
			thorDecodePkg::R2:
				baseImm = (insn.r3.func == thorDecodePkg::SLL) ?
					{{(ValueWidth-5){1'b0}}, insn.r3.Rb} : '0;
			default:
				baseImm = '0;
		endcase

		// Prefix supplies everything above bit 22
		if (pendValid && baseImm != '0)
			immNext = {{(ValueWidth-PayloadWidth-23){pendPayload[PayloadWidth-1]}},
				pendPayload, baseImm[22:0]};
		else
			immNext = baseImm;
	end

	// ============================
	// Prefix tracking
	// ============================
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			imm <= '0;
			isPrefix <= 1'b0;
			pendValid <= 1'b0;
		end
		else
		begin
			imm <= immNext;
			isPrefix <= insnValid & isExi;
			// Idle cycles leave the pending prefix alone
			if (insnValid)
				pendValid <= isExi;
		end
	end

	always_ff @(posedge clk)
	begin
		if (insnValid && isExi)
			pendPayload <= insn.prefix.payload;
	end

endmodule

//--- src/memClassify.sv
`timescale 1ns/100ps
// ============================
// Memory classification
// Load/store kind, access size and multi-cycle flag
// ============================
module memClassify (
	input  logic clk,
	input  logic rstN,
	input  thorDecodePkg::insnFmt insn,
	input  logic insnValid,
	output logic isLoad,
	output logic loadZeroExt,
	output logic isStore,
	output thorDecodePkg::memSizeT memSize,
	output logic multiCycle
);

	thorDecodePkg::opcodeT op;
	logic loadNext;
	logic storeNext;
	logic zextNext;
	logic mulDiv;
	thorDecodePkg::memSizeT sizeNext;

	assign op = insn.r3.opcode;
	assign loadNext = op inside {thorDecodePkg::LDB, thorDecodePkg::LDBU,
		thorDecodePkg::LDW, thorDecodePkg::LDWU, thorDecodePkg::LDO};
	assign storeNext = op inside {thorDecodePkg::STB, thorDecodePkg::STW, thorDecodePkg::STO};
	assign zextNext = op inside {thorDecodePkg::LDBU, thorDecodePkg::LDWU};
	assign mulDiv = (op == thorDecodePkg::R2) &&
		(insn.r3.func inside {thorDecodePkg::MUL, thorDecodePkg::DIV});

	always_comb
	begin
		case (op)
			thorDecodePkg::LDB, thorDecodePkg::LDBU, thorDecodePkg::STB:
				sizeNext = thorDecodePkg::byteSz;
			thorDecodePkg::LDW, thorDecodePkg::LDWU, thorDecodePkg::STW:
				sizeNext = thorDecodePkg::wydeSz;
			default: sizeNext = thorDecodePkg::octaSz;   // LDO, STO and non-memory
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			isLoad <= 1'b0;
			loadZeroExt <= 1'b0;
			isStore <= 1'b0;
			memSize <= thorDecodePkg::byteSz;
			multiCycle <= 1'b0;
		end
		else
		begin
			isLoad <= loadNext;
			loadZeroExt <= zextNext;
			isStore <= storeNext;
			memSize <= sizeNext;
			multiCycle <= loadNext | storeNext | mulDiv;
		end
	end

endmodule

//--- src/regSelect.sv
`timescale 1ns/100ps
// ============================
// Register selection
// Source and target registers plus write enable
// ============================
module regSelect (
	input  logic clk,
	input  logic rstN,
	input  thorDecodePkg::insnFmt insn,
	input  logic insnValid,
	output thorDecodePkg::RegNum ra,
	output thorDecodePkg::RegNum rb,
	output thorDecodePkg::RegNum rc,
	output thorDecodePkg::RegNum rt,
	output logic rfWrite
);

	thorDecodePkg::opcodeT op;
	thorDecodePkg::RegNum raNext;
	thorDecodePkg::RegNum rcNext;
	thorDecodePkg::RegNum rtNext;
	logic linked;
	logic writeNext;

	assign op = insn.r3.opcode;
	// lk sits at the same bits in jxx and jmp
	assign linked = insn.jmp.lk != 2'd0;

	always_comb
	begin
		case (op)
			thorDecodePkg::RTS: raNext = thorDecodePkg::LinkRegBase;
			thorDecodePkg::JEQ, thorDecodePkg::JNE, thorDecodePkg::JLT:
				raNext = insn.jxx.Ra;
			default: raNext = insn.r3.Ra;
		endcase

		// Store data goes out on the third read port
		case (op)
			thorDecodePkg::STB, thorDecodePkg::STW, thorDecodePkg::STO:
				rcNext = insn.mem.Rt;
			thorDecodePkg::JEQ, thorDecodePkg::JNE, thorDecodePkg::JLT:
				rcNext = insn.jxx.Rc;
			default: rcNext = insn.r3.Rc;
		endcase

		rtNext = insn.r3.Rt;
		writeNext = 1'b0;
		case (op)
			thorDecodePkg::STB, thorDecodePkg::STW, thorDecodePkg::STO,
			thorDecodePkg::EXI, thorDecodePkg::RTS, thorDecodePkg::NOP:
				rtNext = '0;
			thorDecodePkg::JMP, thorDecodePkg::BRA,
			thorDecodePkg::JEQ, thorDecodePkg::JNE, thorDecodePkg::JLT:
			begin
				rtNext = linked ? thorDecodePkg::LinkRegBase + {3'd0, insn.jmp.lk} : '0;
				writeNext = linked;
			end
			thorDecodePkg::R2, thorDecodePkg::ADDI, thorDecodePkg::ANDI,
			thorDecodePkg::ORI, thorDecodePkg::SLTUI,
			thorDecodePkg::LDB, thorDecodePkg::LDBU, thorDecodePkg::LDW,
			thorDecodePkg::LDWU, thorDecodePkg::LDO:
				writeNext = 1'b1;
			default: ;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			ra <= '0;
			rb <= '0;
			rc <= '0;
			rt <= '0;
			rfWrite <= 1'b0;
		end
		else
		begin
			ra <= raNext;
			rb <= insn.r3.Rb;
			rc <= rcNext;
			rt <= rtNext;
			rfWrite <= insnValid & writeNext;
		end
	end

endmodule

//--- src/thorDecodePkg.sv
// ============================
// Thor decode shared definitions
// Opcodes, function codes and the 40-bit instruction formats
// ============================
package thorDecodePkg;

	localparam int InsnWidth = 40;

	typedef logic [4:0] RegNum;

	// Link value k lives in register 28+k
	localparam RegNum LinkRegBase = 5'd28;

	// ============================
	// Encodings
	// ============================
	typedef enum logic [6:0] {
		R2    = 7'd2,
		ADDI  = 7'd4,
		ANDI  = 7'd8,
		ORI   = 7'd9,
		SLTUI = 7'd11,
		JMP   = 7'd32,
		BRA   = 7'd33,
		RTS   = 7'd35,
		JEQ   = 7'd38,
		JNE   = 7'd39,
		JLT   = 7'd40,
		EXI   = 7'd48,
		LDB   = 7'd64,
		LDBU  = 7'd65,
		LDW   = 7'd66,
		LDWU  = 7'd67,
		LDO   = 7'd70,
		STB   = 7'd80,
		STW   = 7'd81,
		STO   = 7'd83,
		NOP   = 7'd127
	} opcodeT;

	// Function field of the R2 group
	typedef enum logic [6:0] {
		ADD = 7'd4,
		SUB = 7'd5,
		AND = 7'd8,
		OR  = 7'd9,
		MUL = 7'd16,
		DIV = 7'd19,
		SLL = 7'd32
	} funcT;

	typedef enum logic [1:0] {
		byteSz  = 2'd0,
		wydeSz  = 2'd1,
		tetraSz = 2'd2,
		octaSz  = 2'd3
	} memSizeT;

	// ============================
	// Formats, highest field first
	// ============================
	typedef struct packed {
		logic [InsnWidth-35:0] spare;
		funcT func;
		RegNum Rc;
		RegNum Rb;
		RegNum Ra;
		RegNum Rt;
		opcodeT opcode;
	} r3Fmt;

	typedef struct packed {
		logic [22:0] imm;
		RegNum Ra;
		RegNum Rt;
		opcodeT opcode;
	} riFmt;

	// Rt carries the data register on stores
	typedef struct packed {
		logic [22:0] disp;
		RegNum Ra;
		RegNum Rt;
		opcodeT opcode;
	} memFmt;

	typedef struct packed {
		logic [InsnWidth-38:0] spare;
		logic [17:0] tgt;
		RegNum Rc;
		RegNum Ra;
		logic [1:0] lk;
		opcodeT opcode;
	} jxxFmt;

	typedef struct packed {
		logic [InsnWidth-10:0] tgt;
		logic [1:0] lk;
		opcodeT opcode;
	} jmpFmt;

	// Upper immediate bits for the word that follows
	typedef struct packed {
		logic [InsnWidth-8:0] payload;
		opcodeT opcode;
	} prefixFmt;

	typedef union packed {
		r3Fmt r3;
		riFmt ri;
		memFmt mem;
		jxxFmt jxx;
		jmpFmt jmp;
		prefixFmt prefix;
	} insnFmt;

endpackage

//--- src/thorDecodeStage.sv
`timescale 1ns/100ps
// ============================
// Thor decode stage
// Registered decode record, one cycle after the word
// ============================
module thorDecodeStage #(
	parameter int ValueWidth = 64
) (
	input  logic clk,
	input  logic rstN,
	input  thorDecodePkg::insnFmt insn,
	input  logic insnValid,
	output logic decValid,
	output thorDecodePkg::RegNum ra,
	output thorDecodePkg::RegNum rb,
	output thorDecodePkg::RegNum rc,
	output thorDecodePkg::RegNum rt,
	output logic rfWrite,
	output logic [ValueWidth-1:0] imm,
	output logic isPrefix,
	output logic isLoad,
	output logic loadZeroExt,
	output logic isStore,
	output thorDecodePkg::memSizeT memSize,
	output logic multiCycle,
	output logic isJump,
	output logic isCondBranch,
	output logic isBranch,
	output logic isReturn,
	output logic isFlowChange,
	output logic [ValueWidth-1:0] branchTarget
);

	// Valid follows the word through the single stage
	always_ff @(posedge clk)
	begin
		if (!rstN)
			decValid <= 1'b0;
		else
			decValid <= insnValid;
	end

	regSelect uRegSelect (
		.clk      (clk),
		.rstN     (rstN),
		.insn     (insn),
		.insnValid(insnValid),
		.ra       (ra),
		.rb       (rb),
		.rc       (rc),
		.rt       (rt),
		.rfWrite  (rfWrite)
	);

	immBuild #(.ValueWidth(ValueWidth)) uImmBuild (
		.clk      (clk),
		.rstN     (rstN),
		.insn     (insn),
		.insnValid(insnValid),
		.imm      (imm),
		.isPrefix (isPrefix)
	);

	memClassify uMemClassify (
		.clk        (clk),
		.rstN       (rstN),
		.insn       (insn),
		.insnValid  (insnValid),
		.isLoad     (isLoad),
		.loadZeroExt(loadZeroExt),
		.isStore    (isStore),
		.memSize    (memSize),
		.multiCycle (multiCycle)
	);

	flowDecode #(.ValueWidth(ValueWidth)) uFlowDecode (
		.clk         (clk),
		.rstN        (rstN),
		.insn        (insn),
		.insnValid   (insnValid),
		.isJump      (isJump),
		.isCondBranch(isCondBranch),
		.isBranch    (isBranch),
		.isReturn    (isReturn),
		.isFlowChange(isFlowChange),
		.branchTarget(branchTarget)
	);

endmodule

//--- thorDecode.f
src/thorDecodePkg.sv
src/regSelect.sv
src/immBuild.sv
src/memClassify.sv
src/flowDecode.sv
src/thorDecodeStage.sv
verification/thorDecodeProperties.sv
verification/thorDecodeTb.sv

//--- verification/thorDecodeProperties.sv
`timescale 1ns/100ps
// ============================
// Decode stage assertions
// Valid timing and flag consistency
// ============================
module thorDecodeProperties (
	input logic clk,
	input logic rstN,
	input logic insnValid,
	input logic decValid,
	input logic isLoad,
	input logic isStore,
	input logic isJump,
	input logic isCondBranch,
	input logic isBranch,
	input logic isReturn,
	input logic isFlowChange
);

	// A reset edge leaves the record empty
	assert property (@(posedge clk) !rstN |=> !decValid)
		else $error("decValid high on the cycle after reset");

	assert property (@(posedge clk) disable iff (!rstN)
		$past(rstN) |-> decValid == $past(insnValid))
		else $error("decValid does not follow insnValid by one cycle");

	assert property (@(posedge clk) disable iff (!rstN) !(isLoad && isStore))
		else $error("isLoad and isStore high together");

	assert property (@(posedge clk) disable iff (!rstN)
		isFlowChange == (isJump || isCondBranch || isBranch || isReturn))
		else $error("isFlowChange disagrees with the flow flags");

endmodule

bind thorDecodeStage thorDecodeProperties uProps (
	.clk         (clk),
	.rstN        (rstN),
	.insnValid   (insnValid),
	.decValid    (decValid),
	.isLoad      (isLoad),
	.isStore     (isStore),
	.isJump      (isJump),
	.isCondBranch(isCondBranch),
	.isBranch    (isBranch),
	.isReturn    (isReturn),
	.isFlowChange(isFlowChange)
);

//--- verification/thorDecodeTb.sv
`timescale 1ns/100ps
// ============================
// Thor decode stage testbench
// Random word stream checked against a decode model
// ============================
module thorDecodeTb;

	localparam int ValueWidth = 64;
	localparam int ResetCycles = 8;
	localparam int StimCycles = 2000;
	localparam int TimeoutLimit = ResetCycles + StimCycles + 100;

	typedef struct packed {
		thorDecodePkg::RegNum ra;
		thorDecodePkg::RegNum rb;
		thorDecodePkg::RegNum rc;
		thorDecodePkg::RegNum rt;
		logic rfWrite;
		logic [ValueWidth-1:0] imm;
		logic isPrefix;
		logic isLoad;
		logic loadZeroExt;
		logic isStore;
		thorDecodePkg::memSizeT memSize;
		logic multiCycle;
		logic isJump;
		logic isCondBranch;
		logic isBranch;
		logic isReturn;
		logic isFlowChange;
		logic [ValueWidth-1:0] branchTarget;
	} decRec;

	logic clk;
	logic rstN;
	thorDecodePkg::insnFmt insn;
	logic insnValid;
	logic decValid;
	thorDecodePkg::RegNum ra;
	thorDecodePkg::RegNum rb;
	thorDecodePkg::RegNum rc;
	thorDecodePkg::RegNum rt;
	logic rfWrite;
	logic [ValueWidth-1:0] imm;
	logic isPrefix;
	logic isLoad;
	logic loadZeroExt;
	logic isStore;
	thorDecodePkg::memSizeT memSize;
	logic multiCycle;
	logic isJump;
	logic isCondBranch;
	logic isBranch;
	logic isReturn;
	logic isFlowChange;
	logic [ValueWidth-1:0] branchTarget;

	integer seed = 32'h1f74_129b;
	int cycleCount = 0;
	int validErrors = 0;
	int regErrors = 0;
	int immErrors = 0;
	int memErrors = 0;
	int flowErrors = 0;
	int pick;
	int cyc;
	logic prevValid = 1'b0;
	thorDecodePkg::insnFmt word;
	decRec expQ[$];
	decRec expRec;
	thorDecodePkg::opcodeT opList [20];
	thorDecodePkg::funcT funcList [7];

	// Model copy of the prefix state
	logic pendModel = 1'b0;
	logic [32:0] payloadModel = '0;

	thorDecodeStage #(.ValueWidth(ValueWidth)) uut (.*);

	always #10 clk = ~clk;

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TimeoutLimit)
		begin
			$display("timeout: decode stream did not finish");
			$display("Checks failed");
			$finish;
		end
	end

	function automatic logic [ValueWidth-1:0] widen18(input logic [17:0] v);
		return {{(ValueWidth-18){v[17]}}, v};
	endfunction

	function automatic logic [ValueWidth-1:0] widen23(input logic [22:0] v);
		return {{(ValueWidth-23){v[22]}}, v};
	endfunction

	function automatic logic [ValueWidth-1:0] widen31(input logic [30:0] v);
		return {{(ValueWidth-31){v[30]}}, v};
	endfunction

	function automatic logic [ValueWidth-1:0] widen33(input logic [32:0] v);
		return {{(ValueWidth-33){v[32]}}, v};
	endfunction

	// ============================
	// Decode model
	// ============================
	function automatic decRec predict(input thorDecodePkg::insnFmt w, input logic pend,
		input logic [32:0] payload);
		decRec e;
		thorDecodePkg::opcodeT op;
		logic loadOp;
		logic storeOp;
		logic condOp;
		logic linkOp;
		logic [1:0] lk;
		logic [ValueWidth-1:0] base;
		e = '0;
		op = w.r3.opcode;
		loadOp = op inside {thorDecodePkg::LDB, thorDecodePkg::LDBU, thorDecodePkg::LDW,
			thorDecodePkg::LDWU, thorDecodePkg::LDO};
		storeOp = op inside {thorDecodePkg::STB, thorDecodePkg::STW, thorDecodePkg::STO};
		condOp = op inside {thorDecodePkg::JEQ, thorDecodePkg::JNE, thorDecodePkg::JLT};
		linkOp = condOp || op == thorDecodePkg::JMP || op == thorDecodePkg::BRA;
		lk = condOp ? w.jxx.lk : w.jmp.lk;

		if (op == thorDecodePkg::RTS)
			e.ra = thorDecodePkg::LinkRegBase;
		else
			e.ra = condOp ? w.jxx.Ra : w.r3.Ra;
		e.rb = w.r3.Rb;
		if (storeOp)
			e.rc = w.mem.Rt;
		else
			e.rc = condOp ? w.jxx.Rc : w.r3.Rc;
		if (storeOp || op inside {thorDecodePkg::EXI, thorDecodePkg::RTS, thorDecodePkg::NOP})
			e.rt = '0;
		else if (linkOp)
			e.rt = (lk != 2'd0) ? thorDecodePkg::LinkRegBase + thorDecodePkg::RegNum'(lk) : '0;
		else
			e.rt = w.r3.Rt;
		e.rfWrite = loadOp || (linkOp && lk != 2'd0) || op inside {thorDecodePkg::R2,
			thorDecodePkg::ADDI, thorDecodePkg::ANDI, thorDecodePkg::ORI, thorDecodePkg::SLTUI};

		base = '0;
		if (op == thorDecodePkg::ADDI)
			base = widen23(w.ri.imm);
		else if (loadOp || storeOp)
			base = widen23(w.mem.disp);
		else if (op == thorDecodePkg::ANDI)
			base = {{(ValueWidth-23){1'b1}}, w.ri.imm};
		else if (op == thorDecodePkg::ORI || op == thorDecodePkg::SLTUI)
			base = {{(ValueWidth-23){1'b0}}, w.ri.imm};
		else if (op == thorDecodePkg::R2 && w.r3.func == thorDecodePkg::SLL)
			base = {{(ValueWidth-5){1'b0}}, w.r3.Rb};
		// Payload lands above the low 23 bits
		if (pend && base != '0)
			e.imm = (widen33(payload) << 23) | {{(ValueWidth-23){1'b0}}, base[22:0]};
		else
			e.imm = base;
		e.isPrefix = op == thorDecodePkg::EXI;

		e.isLoad = loadOp;
		e.isStore = storeOp;
		e.loadZeroExt = op inside {thorDecodePkg::LDBU, thorDecodePkg::LDWU};
		if (op inside {thorDecodePkg::LDB, thorDecodePkg::LDBU, thorDecodePkg::STB})
			e.memSize = thorDecodePkg::byteSz;
		else if (op inside {thorDecodePkg::LDW, thorDecodePkg::LDWU, thorDecodePkg::STW})
			e.memSize = thorDecodePkg::wydeSz;
		else
			e.memSize = thorDecodePkg::octaSz;
		e.multiCycle = loadOp || storeOp || (op == thorDecodePkg::R2 &&
			w.r3.func inside {thorDecodePkg::MUL, thorDecodePkg::DIV});

		e.isJump = op == thorDecodePkg::JMP;
		e.isCondBranch = condOp;
		e.isBranch = op == thorDecodePkg::BRA;
		e.isReturn = op == thorDecodePkg::RTS;
		e.isFlowChange = e.isJump || condOp || e.isBranch || e.isReturn;
		if (condOp)
			e.branchTarget = widen18(w.jxx.tgt) << 1;
		else if (e.isJump || e.isBranch)
			e.branchTarget = widen31(w.jmp.tgt) << 1;
		return e;
	endfunction

	// ============================
	// Compare tasks
	// ============================
	task automatic checkRegs(input thorDecodePkg::RegNum eRa, input thorDecodePkg::RegNum eRb,
		input thorDecodePkg::RegNum eRc, input thorDecodePkg::RegNum eRt, input logic eWr);
		if (ra !== eRa || rb !== eRb || rc !== eRc || rt !== eRt || rfWrite !== eWr)
		begin
			regErrors++;
			$display("MISMATCH at %0t: regs got %0d/%0d/%0d/%0d/%0b exp %0d/%0d/%0d/%0d/%0b",
				$time, ra, rb, rc, rt, rfWrite, eRa, eRb, eRc, eRt, eWr);
		end
	endtask

	task automatic checkImm(input logic [ValueWidth-1:0] eImm, input logic ePrefix);
		if (imm !== eImm || isPrefix !== ePrefix)
		begin
			immErrors++;
			$display("MISMATCH at %0t: imm/isPrefix got %h/%0b expected %h/%0b",
				$time, imm, isPrefix, eImm, ePrefix);
		end
	endtask

	task automatic checkMem(input logic eLoad, input logic eZext, input logic eStore,
		input thorDecodePkg::memSizeT eSize, input logic eMulti);
		if (isLoad !== eLoad || loadZeroExt !== eZext || isStore !== eStore ||
			memSize !== eSize || multiCycle !== eMulti)
		begin
			memErrors++;
			$display("MISMATCH at %0t: mem got %0b/%0b/%0b/%0d/%0b exp %0b/%0b/%0b/%0d/%0b",
				$time, isLoad, loadZeroExt, isStore, memSize, multiCycle,
				eLoad, eZext, eStore, eSize, eMulti);
		end
	endtask

	task automatic checkFlow(input logic eJump, input logic eCond, input logic eBra,
		input logic eRet, input logic eFlow, input logic [ValueWidth-1:0] eTgt);
		if (isJump !== eJump || isCondBranch !== eCond || isBranch !== eBra ||
			isReturn !== eRet || isFlowChange !== eFlow || branchTarget !== eTgt)
		begin
			flowErrors++;
			$display("MISMATCH at %0t: flow got %0b/%0b/%0b/%0b/%0b/%h exp %0b/%0b/%0b/%0b/%0b/%h",
				$time, isJump, isCondBranch, isBranch, isReturn, isFlowChange, branchTarget,
				eJump, eCond, eBra, eRet, eFlow, eTgt);
		end
	endtask

	task automatic makeWord(output thorDecodePkg::insnFmt w);
		logic [39:0] raw;
		int kind;
		raw[31:0] = $random(seed);
		raw[39:32] = 8'($random(seed));
		w = raw;
		kind = $unsigned($random(seed)) % 100;
		if (kind < 15)
			w.prefix.opcode = thorDecodePkg::EXI;
		else
		begin
			w.r3.opcode = opList[$unsigned($random(seed)) % 20];
			if (w.r3.opcode == thorDecodePkg::R2)
				w.r3.func = funcList[$unsigned($random(seed)) % 7];
		end
	endtask

	// ============================
	// Stimulus and checking
	// ============================
	initial
	begin
		clk = 1'b0;
		rstN = 1'b0;
		insn = '0;
		insnValid = 1'b0;
		opList = '{thorDecodePkg::R2, thorDecodePkg::ADDI, thorDecodePkg::ANDI,
			thorDecodePkg::ORI, thorDecodePkg::SLTUI, thorDecodePkg::LDB, thorDecodePkg::LDBU,
			thorDecodePkg::LDW, thorDecodePkg::LDWU, thorDecodePkg::LDO, thorDecodePkg::STB,
			thorDecodePkg::STW, thorDecodePkg::STO, thorDecodePkg::JEQ, thorDecodePkg::JNE,
			thorDecodePkg::JLT, thorDecodePkg::JMP, thorDecodePkg::BRA, thorDecodePkg::RTS,
			thorDecodePkg::NOP};
		funcList = '{thorDecodePkg::ADD, thorDecodePkg::SUB, thorDecodePkg::AND,
			thorDecodePkg::OR, thorDecodePkg::MUL, thorDecodePkg::DIV, thorDecodePkg::SLL};

		repeat (ResetCycles) @(negedge clk);
		// Record must be empty while reset is held
		if (decValid !== 1'b0 || rfWrite !== 1'b0 || isLoad !== 1'b0 || isStore !== 1'b0 ||
			multiCycle !== 1'b0 || isFlowChange !== 1'b0 || isPrefix !== 1'b0)
		begin
			validErrors++;
			$display("MISMATCH at %0t: control outputs not low during reset", $time);
		end
		checkRegs('0, '0, '0, '0, 1'b0);
		checkImm('0, 1'b0);
		checkMem(1'b0, 1'b0, 1'b0, thorDecodePkg::byteSz, 1'b0);
		checkFlow(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, '0);
		rstN = 1'b1;

		for (cyc = 0; cyc <= StimCycles; cyc++)
		begin
			@(negedge clk);
			if (decValid !== prevValid)
			begin
				validErrors++;
				$display("MISMATCH at %0t: decValid got %0b expected %0b",
					$time, decValid, prevValid);
			end
			if (prevValid)
			begin
				if (expQ.size() == 0)
				begin
					validErrors++;
					$display("Decode record at %0t has no word to match it", $time);
				end
				else
				begin
					expRec = expQ.pop_front();
					checkRegs(expRec.ra, expRec.rb, expRec.rc, expRec.rt, expRec.rfWrite);
					checkImm(expRec.imm, expRec.isPrefix);
					checkMem(expRec.isLoad, expRec.loadZeroExt, expRec.isStore,
						expRec.memSize, expRec.multiCycle);
					checkFlow(expRec.isJump, expRec.isCondBranch, expRec.isBranch,
						expRec.isReturn, expRec.isFlowChange, expRec.branchTarget);
				end
			end
			// An idle word writes no register and starts no prefix
			else if (rfWrite !== 1'b0 || isPrefix !== 1'b0)
			begin
				validErrors++;
				$display("MISMATCH at %0t: rfWrite/isPrefix got %0b/%0b after an idle cycle",
					$time, rfWrite, isPrefix);
			end

			// Idle cycles still carry a random word
			pick = $unsigned($random(seed)) % 100;
			makeWord(word);
			insn = word;
			insnValid = (pick >= 10) && (cyc < StimCycles);
			if (insnValid)
			begin
				expQ.push_back(predict(word, pendModel, payloadModel));
				pendModel = word.r3.opcode == thorDecodePkg::EXI;
				if (pendModel)
					payloadModel = word.prefix.payload;
			end
			prevValid = insnValid;
		end

		if (expQ.size() != 0)
		begin
			validErrors++;
			$display("%0d words never produced a decode record", expQ.size());
		end
		$display("Error counts: valid=%0d regs=%0d imm=%0d mem=%0d flow=%0d",
			validErrors, regErrors, immErrors, memErrors, flowErrors);
		if (validErrors + regErrors + immErrors + memErrors + flowErrors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule
